//--- verilog/rv_pkg.sv
package rv_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------

  // Data and address word
  typedef logic [31:0] xlen_t;

  // Raw instruction word
  typedef logic [31:0] instr_t;

  // Register index
  typedef logic [4:0] reg_addr_t;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------

  // Major opcodes of the kept instruction set
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLTU   = 4'd6,
    ALU_SLL    = 4'd7,
    ALU_SRL    = 4'd8,
    ALU_SRA    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_t;

  // Write-back source
  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_PC4 = 2'd2
  } res_src_t;

  // Boot address unless the top level overrides it
  localparam xlen_t RESET_PC_DEFAULT = 32'h0000_0000;

  // The only SYSTEM encoding that does anything
  localparam instr_t INSTR_EBREAK = 32'h0010_0073;

endpackage

//--- verilog/rv_ctrl_if.sv
`timescale 1ns/1ps

interface rv_ctrl_if;
  import rv_pkg::*;

  // Execute controls
  alu_op_t  alu_op;
  logic     alu_b_imm;
  xlen_t    imm;

  // Write-back and memory
  logic     reg_write;
  res_src_t res_src;
  logic     mem_read;
  logic     mem_write;

  // Flow control
  logic     is_branch;
  logic     branch_ne;
  logic     is_jal;
  logic     is_ebreak;

  // Decoder side
  modport dec(
    output alu_op, alu_b_imm, imm, reg_write, res_src, mem_read, mem_write,
    output is_branch, branch_ne, is_jal, is_ebreak
  );

  // Datapath side
  modport dp(
    input alu_op, alu_b_imm, imm, reg_write, res_src, mem_read, mem_write,
    input is_branch, branch_ne, is_jal, is_ebreak
  );

endinterface

//--- verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input rv_pkg::instr_t instr,
  rv_ctrl_if.dec        ctrl
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       funct7_alt;

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;

  // Shared funct3 map for OP and OP_IMM
  // SUB only exists in the register form
  function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt,
                                              input logic allow_sub);
    alu_op_t op;
    case (f3)
      3'b000:  op = (alt && allow_sub) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode     = opcode_t'(instr[6:0]);
  assign funct3     = instr[14:12];
  assign funct7_alt = instr[30];

  // --------------------------------------------------
  // Immediates, all sign-extended from bit 31
  // --------------------------------------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // --------------------------------------------------
  // Control decode
  // --------------------------------------------------
  always_comb begin
    // Everything inactive, so unknown opcodes act as no-ops
    ctrl.alu_op    = ALU_ADD;
    ctrl.alu_b_imm = 1'b0;
    ctrl.imm       = '0;
    ctrl.reg_write = 1'b0;
    ctrl.res_src   = RES_ALU;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.is_branch = 1'b0;
    ctrl.branch_ne = 1'b0;
    ctrl.is_jal    = 1'b0;
    ctrl.is_ebreak = 1'b0;

    case (opcode)
      OPC_OP: begin
        ctrl.alu_op    = alu_from_funct3(funct3, funct7_alt, 1'b1);
        ctrl.reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        // instr[30] only matters for the right shifts here
        ctrl.alu_op    = alu_from_funct3(funct3, funct7_alt, 1'b0);
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_i;
        ctrl.reg_write = 1'b1;
      end
      OPC_LUI: begin
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      OPC_LOAD: begin
        // Word loads only, address is rs1 + imm
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_i;
        ctrl.reg_write = 1'b1;
        ctrl.res_src   = RES_MEM;
        ctrl.mem_read  = 1'b1;
      end
      OPC_STORE: begin
        ctrl.alu_b_imm = 1'b1;
        ctrl.imm       = imm_s;
        ctrl.mem_write = 1'b1;
      end
      OPC_BRANCH: begin
        // BEQ and BNE, compare by subtraction
        if (funct3[2:1] == 2'b00) begin
          ctrl.alu_op    = ALU_SUB;
          ctrl.imm       = imm_b;
          ctrl.is_branch = 1'b1;
          ctrl.branch_ne = funct3[0];
        end
      end
      OPC_JAL: begin
        ctrl.imm       = imm_j;
        ctrl.reg_write = 1'b1;
        ctrl.res_src   = RES_PC4;
        ctrl.is_jal    = 1'b1;
      end
      OPC_SYSTEM: begin
        ctrl.is_ebreak = (instr == INSTR_EBREAK);
      end
      default: begin
      end
    endcase
  end

endmodule

//--- verilog/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch #(
  parameter rv_pkg::xlen_t RESET_PC = rv_pkg::RESET_PC_DEFAULT
) (
  input  logic          clk,
  input  logic          rst_n,
  rv_ctrl_if.dp         ctrl,
  input  logic          alu_zero,
  output rv_pkg::xlen_t pc,
  output rv_pkg::xlen_t pc_plus4,
  output logic          halted
);
  import rv_pkg::*;

  xlen_t pc_target;
  xlen_t pc_next;
  logic  take;
  logic  hold;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + ctrl.imm;

  // BEQ taken on zero, BNE on nonzero
  assign take = ctrl.is_jal || (ctrl.is_branch && (alu_zero ^ ctrl.branch_ne));

  // Stop on EBREAK itself so the halted pc points at it
  assign hold = halted || ctrl.is_ebreak;

  always_comb begin
    if (hold) begin
      pc_next = pc;
    end else if (take) begin
      pc_next = pc_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else begin
      pc <= pc_next;
      // Sticky until reset
      if (ctrl.is_ebreak) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst_n,
  rv_ctrl_if.dp             ctrl,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::reg_addr_t rd_addr,
  input  rv_pkg::xlen_t     alu_result,
  input  rv_pkg::xlen_t     load_data,
  input  rv_pkg::xlen_t     pc_plus4,
  output rv_pkg::xlen_t     rs1_data,
  output rv_pkg::xlen_t     rs2_data
);
  import rv_pkg::*;

  // x1..x31, x0 is not stored
  xlen_t regs [1:31];
  xlen_t rd_data;

  // Write-back select
  always_comb begin
    case (ctrl.res_src)
      RES_MEM: rd_data = load_data;
      RES_PC4: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_write && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Combinational reads, x0 reads as zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- verilog/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  rv_ctrl_if.dp         ctrl,
  input  rv_pkg::xlen_t rs1_data,
  input  rv_pkg::xlen_t rs2_data,
  output rv_pkg::xlen_t result,
  output logic          zero
);
  import rv_pkg::*;

  xlen_t      b_op;
  logic [4:0] shamt;

  // Operand B from rs2 or the immediate
  assign b_op  = ctrl.alu_b_imm ? ctrl.imm : rs2_data;
  assign shamt = b_op[4:0];

  // --------------------------------------------------
  // Operation select
  // --------------------------------------------------
  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    result = rs1_data + b_op;
      ALU_SUB:    result = rs1_data - b_op;
      ALU_AND:    result = rs1_data & b_op;
      ALU_OR:     result = rs1_data | b_op;
      ALU_XOR:    result = rs1_data ^ b_op;
      // Set-less-than, zero-extended flag
      ALU_SLT:    result = xlen_t'($signed(rs1_data) < $signed(b_op));
      ALU_SLTU:   result = xlen_t'(rs1_data < b_op);
      ALU_SLL:    result = rs1_data << shamt;
      ALU_SRL:    result = rs1_data >> shamt;
      ALU_SRA:    result = xlen_t'($signed(rs1_data) >>> shamt);
      // LUI goes straight through
      ALU_PASS_B: result = b_op;
      default:    result = rs1_data + b_op;
    endcase
  end

  // Branch compare, SUB result of zero means equal
  assign zero = (result == '0);

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter rv_pkg::xlen_t RESET_PC = rv_pkg::RESET_PC_DEFAULT
) (
  input  logic           clk,
  input  logic           rst_n,

  // Instruction memory, read in the same cycle
  output rv_pkg::xlen_t  imem_raddr,
  input  rv_pkg::instr_t imem_rdata,

  // Data memory read
  output logic           dmem_ren,
  output rv_pkg::xlen_t  dmem_raddr,
  input  rv_pkg::xlen_t  dmem_rdata,

  // Data memory write, taken on the edge
  output logic           dmem_we,
  output rv_pkg::xlen_t  dmem_waddr,
  output rv_pkg::xlen_t  dmem_wdata,

  output logic           ebreak
);
  import rv_pkg::*;

  // Instruction fields
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;

  // Datapath
  xlen_t pc;
  xlen_t pc_plus4;
  xlen_t rs1_data;
  xlen_t rs2_data;
  xlen_t alu_result;
  logic  alu_zero;
  logic  halted;

  rv_ctrl_if ctrl ();

  assign rs1_addr = imem_rdata[19:15];
  assign rs2_addr = imem_rdata[24:20];
  assign rd_addr  = imem_rdata[11:7];

  // --------------------------------------------------
  // Control and datapath
  // --------------------------------------------------
  rv_decode u_decode (
    .instr(imem_rdata),
    .ctrl (ctrl.dec)
  );

  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl    (ctrl.dp),
    .alu_zero(alu_zero),
    .pc      (pc),
    .pc_plus4(pc_plus4),
    .halted  (halted)
  );

  rv_regfile u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl.dp),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rd_addr   (rd_addr),
    .alu_result(alu_result),
    .load_data (dmem_rdata),
    .pc_plus4  (pc_plus4),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  rv_alu u_alu (
    .ctrl    (ctrl.dp),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .result  (alu_result),
    .zero    (alu_zero)
  );

  // Memory ports
  assign imem_raddr = pc;
  // LW and SW both address through the ALU sum
  assign dmem_raddr = alu_result;
  assign dmem_waddr = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_ren   = ctrl.mem_read;
  assign dmem_we    = ctrl.mem_write;
  assign ebreak     = halted;

endmodule

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  localparam int    PERIOD       = 4;
  localparam int    SEED         = 46632;
  localparam int    MEM_WORDS    = 256;
  localparam int    HALT_CYCLES  = 8;
  localparam int    WATCH_MARGIN = 20;
  localparam xlen_t RESET_PC     = 32'h0000_0040;

  // Test tags, one per instruction word
  localparam int T_ALU  = 1;
  localparam int T_MEM  = 2;
  localparam int T_BR   = 3;
  localparam int T_JAL  = 4;
  localparam int T_HALT = 5;

  // R-type order: ADD SUB AND OR XOR SLT SLTU SLL SRL SRA
  localparam logic [2:0] R_F3 [10] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
  localparam logic [9:0] R_ALT     = 10'b10_0000_0010;
  // I-type order: ADDI ANDI ORI XORI SLTI SLTIU SLLI SRLI SRAI
  localparam logic [2:0] I_F3 [9]  = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
  localparam logic [8:0] I_ALT     = 9'b1_0000_0000;

  logic   clk;
  logic   rst_n;
  xlen_t  imem_raddr;
  instr_t imem_rdata;
  logic   dmem_ren;
  xlen_t  dmem_raddr;
  xlen_t  dmem_rdata;
  logic   dmem_we;
  xlen_t  dmem_waddr;
  xlen_t  dmem_wdata;
  logic   ebreak;

  xlen_t imem     [MEM_WORDS];
  int    test_tag [MEM_WORDS];
  xlen_t dmem     [MEM_WORDS];
  xlen_t m_mem    [MEM_WORDS];

  // Reference model state
  xlen_t m_pc;
  xlen_t m_regs [32];
  logic  m_halted;
  logic  first_cycle;
  // Reference model per-cycle results
  instr_t m_ins;
  xlen_t  m_rs1;
  xlen_t  m_rs2;
  xlen_t  m_imm_i;
  xlen_t  m_rd_val;
  xlen_t  m_next_pc;
  logic   m_wr;
  logic   m_brk;
  logic   exp_we;
  logic   exp_ren;
  xlen_t  exp_addr;
  xlen_t  exp_wdata;

  int ptr;
  int prog_len    = 0;
  int error_count = 0;

  rv_core #(
    .RESET_PC(RESET_PC)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .ebreak    (ebreak)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------
  // Memory models
  // --------------------------------------------------
  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_raddr[9:2]];

  always @(posedge clk) begin
    if (rst_n && dmem_we) begin
      dmem[dmem_waddr[9:2]] <= dmem_wdata;
    end
  end

  // Initial data, mixes every bit of the word index
  function automatic xlen_t fill_word(input int w);
    return (xlen_t'(w) * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
  endfunction

  // --------------------------------------------------
  // Reference model, one instruction per clock
  // --------------------------------------------------
  function automatic xlen_t expected_alu(input logic [2:0] f3, input logic alt,
                                         input logic reg_form, input xlen_t a, input xlen_t b);
    case (f3)
      3'd0:    return (alt && reg_form) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  always_comb begin
    m_ins     = imem[m_pc[9:2]];
    m_rs1     = m_regs[m_ins[19:15]];
    m_rs2     = m_regs[m_ins[24:20]];
    m_imm_i   = {{20{m_ins[31]}}, m_ins[31:20]};
    m_rd_val  = '0;
    m_wr      = 1'b0;
    m_brk     = 1'b0;
    exp_we    = 1'b0;
    exp_ren   = 1'b0;
    exp_addr  = '0;
    exp_wdata = m_rs2;
    m_next_pc = m_pc + 32'd4;
    case (m_ins[6:0])
      OPC_OP: begin
        m_wr     = 1'b1;
        m_rd_val = expected_alu(m_ins[14:12], m_ins[30], 1'b1, m_rs1, m_rs2);
      end
      OPC_OP_IMM: begin
        m_wr     = 1'b1;
        m_rd_val = expected_alu(m_ins[14:12], m_ins[30], 1'b0, m_rs1, m_imm_i);
      end
      OPC_LUI: begin
        m_wr     = 1'b1;
        m_rd_val = {m_ins[31:12], 12'h000};
      end
      OPC_LOAD: begin
        m_wr     = 1'b1;
        exp_ren  = 1'b1;
        exp_addr = m_rs1 + m_imm_i;
        m_rd_val = m_mem[exp_addr[9:2]];
      end
      OPC_STORE: begin
        exp_we   = 1'b1;
        exp_addr = m_rs1 + {{20{m_ins[31]}}, m_ins[31:25], m_ins[11:7]};
      end
      OPC_BRANCH: begin
        if ((m_ins[14:12] == 3'd0 && m_rs1 == m_rs2) ||
            (m_ins[14:12] == 3'd1 && m_rs1 != m_rs2)) begin
          m_next_pc = m_pc + {{19{m_ins[31]}}, m_ins[31], m_ins[7], m_ins[30:25],
                              m_ins[11:8], 1'b0};
        end
      end
      OPC_JAL: begin
        m_wr      = 1'b1;
        m_rd_val  = m_pc + 32'd4;
        m_next_pc = m_pc + {{11{m_ins[31]}}, m_ins[31], m_ins[19:12], m_ins[20],
                            m_ins[30:21], 1'b0};
      end
      OPC_SYSTEM: m_brk = (m_ins == INSTR_EBREAK);
      default: begin
      end
    endcase
    // Halts on the EBREAK itself
    if (m_halted || m_brk) begin
      m_next_pc = m_pc;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      m_pc        <= RESET_PC;
      m_halted    <= 1'b0;
      first_cycle <= 1'b1;
      for (int i = 0; i < 32; i++) begin
        m_regs[i] <= '0;
      end
    end else begin
      first_cycle <= 1'b0;
      m_pc        <= m_next_pc;
      if (m_wr && m_ins[11:7] != 5'd0) begin
        m_regs[m_ins[11:7]] <= m_rd_val;
      end
      if (exp_we) begin
        m_mem[exp_addr[9:2]] <= exp_wdata;
      end
      if (m_brk) begin
        m_halted <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Instruction encoders
  // --------------------------------------------------
  function automatic instr_t r_word(input logic f7_alt, input logic [4:0] rs2, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd);
    return {1'b0, f7_alt, 5'd0, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic instr_t i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic instr_t b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic instr_t u_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic instr_t j_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic emit(input instr_t word, input int tag);
    imem[ptr]     = word;
    test_tag[ptr] = tag;
    ptr++;
  endtask

  // --------------------------------------------------
  // Program
  // --------------------------------------------------
  task automatic build_program();
    int          slot;
    logic [11:0] imm;
    slot = 'h100;
    for (int w = 0; w < MEM_WORDS; w++) begin
      // Runaway fetch halts
      imem[w]     = INSTR_EBREAK;
      test_tag[w] = T_HALT;
      dmem[w]     = fill_word(w);
      m_mem[w]    = fill_word(w);
    end
    ptr = int'(RESET_PC[9:2]);
    for (int r = 0; r < 2; r++) begin
      // Random operands in x1 and x2
      emit(u_word(20'($urandom), 5'd1), T_ALU);
      emit(i_word(12'($urandom), 5'd1, 3'd0, 5'd1, OPC_OP_IMM), T_ALU);
      emit(u_word(20'($urandom), 5'd2), T_ALU);
      emit(i_word(12'($urandom), 5'd2, 3'd0, 5'd2, OPC_OP_IMM), T_ALU);
      for (int k = 0; k < 10; k++) begin
        emit(r_word(R_ALT[k], 5'd2, 5'd1, R_F3[k], 5'd3), T_ALU);
        emit(s_word(12'(slot), 5'd3, 5'd0), T_ALU);
        slot += 4;
      end
      for (int k = 0; k < 9; k++) begin
        // Shifts carry funct7 in the upper immediate bits
        if (I_F3[k] == 3'd1 || I_F3[k] == 3'd5) begin
          imm = {1'b0, I_ALT[k], 5'd0, 5'($urandom)};
        end else begin
          imm = 12'($urandom);
        end
        emit(i_word(imm, 5'd1, I_F3[k], 5'd3, OPC_OP_IMM), T_ALU);
        emit(s_word(12'(slot), 5'd3, 5'd0), T_ALU);
        slot += 4;
      end
    end
    // x0 ignores the write
    emit(i_word(12'h7, 5'd1, 3'd0, 5'd0, OPC_OP_IMM), T_ALU);
    emit(s_word(12'(slot), 5'd0, 5'd0), T_ALU);
    // Store, load back, store the loaded copy
    emit(u_word(20'($urandom), 5'd4), T_MEM);
    emit(i_word(12'($urandom), 5'd4, 3'd0, 5'd4, OPC_OP_IMM), T_MEM);
    emit(s_word(12'h300, 5'd4, 5'd0), T_MEM);
    emit(i_word(12'h300, 5'd0, 3'b010, 5'd5, OPC_LOAD), T_MEM);
    emit(s_word(12'h304, 5'd5, 5'd0), T_MEM);
    // x6 mirrors x1 for the equal case
    emit(i_word(12'h0, 5'd1, 3'd0, 5'd6, OPC_OP_IMM), T_BR);
    for (int k = 0; k < 4; k++) begin
      emit(b_word(13'd8, (k == 0 || k == 3) ? 5'd6 : 5'd2, 5'd1, 3'(k / 2)), T_BR);
      emit(i_word(12'h1, 5'd8, 3'd0, 5'd8, OPC_OP_IMM), T_BR);
    end
    // JAL over two fillers, then store the link
    emit(j_word(21'd12, 5'd9), T_JAL);
    emit(i_word(12'h1, 5'd8, 3'd0, 5'd8, OPC_OP_IMM), T_JAL);
    emit(i_word(12'h1, 5'd8, 3'd0, 5'd8, OPC_OP_IMM), T_JAL);
    emit(s_word(12'h308, 5'd9, 5'd0), T_JAL);
    emit(INSTR_EBREAK, T_HALT);
    prog_len = ptr - int'(RESET_PC[9:2]);
  endtask

  // --------------------------------------------------
  // Checks, sampled on the falling edge
  // --------------------------------------------------
  function automatic string test_name();
    if (first_cycle) return "reset";
    if (m_halted) return "halt";
    case (test_tag[m_pc[9:2]])
      T_ALU:   return "alu";
      T_MEM:   return "mem_round_trip";
      T_BR:    return "branch";
      T_JAL:   return "jal";
      default: return "halt";
    endcase
  endfunction

  task automatic report_mismatch(input string test, input string what,
                                 input xlen_t expected, input xlen_t actual);
    error_count++;
    $display("Fail %s: %s expected %08h actual %08h", test, what, expected, actual);
    $display("STATUS: FAIL");
    $fatal(1, "Mismatch in test %s", test);
  endtask

  a_pc: assert property (@(negedge clk) disable iff (!rst_n) imem_raddr == m_pc)
    else report_mismatch(test_name(), "imem_raddr", m_pc, imem_raddr);
  a_we: assert property (@(negedge clk) disable iff (!rst_n) dmem_we == exp_we)
    else report_mismatch(test_name(), "dmem_we", xlen_t'(exp_we), xlen_t'(dmem_we));
  a_ren: assert property (@(negedge clk) disable iff (!rst_n) dmem_ren == exp_ren)
    else report_mismatch(test_name(), "dmem_ren", xlen_t'(exp_ren), xlen_t'(dmem_ren));
  // Load address, only meaningful in a LW cycle
  a_raddr: assert property (@(negedge clk) disable iff (!rst_n)
                            exp_ren |-> dmem_raddr == exp_addr)
    else report_mismatch(test_name(), "dmem_raddr", exp_addr, dmem_raddr);
  a_ebreak: assert property (@(negedge clk) disable iff (!rst_n) ebreak == m_halted)
    else report_mismatch(test_name(), "ebreak", xlen_t'(m_halted), xlen_t'(ebreak));
  a_waddr: assert property (@(negedge clk) disable iff (!rst_n) exp_we |-> dmem_waddr == exp_addr)
    else report_mismatch(test_name(), "dmem_waddr", exp_addr, dmem_waddr);
  a_wdata: assert property (@(negedge clk) disable iff (!rst_n) exp_we |-> dmem_wdata == exp_wdata)
    else report_mismatch(test_name(), "dmem_wdata", exp_wdata, dmem_wdata);

  // --------------------------------------------------
  // Run control
  // --------------------------------------------------
  initial begin
    void'($urandom(SEED));
    rst_n = 1'b0;
    build_program();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    wait (ebreak === 1'b1);
    // Halt must hold for a while
    repeat (HALT_CYCLES) @(posedge clk);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Bound by program length, no loops in the program
  initial begin
    wait (prog_len > 0);
    #((prog_len + HALT_CYCLES + 2 + WATCH_MARGIN) * PERIOD);
    $display("Watchdog expired before the core halted");
    $display("STATUS: FAIL");
    $fatal(1, "Timeout");
  end

endmodule

//--- tb.f
verilog/rv_pkg.sv
verilog/rv_ctrl_if.sv
verilog/rv_decode.sv
verilog/rv_fetch.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_core.sv
sim/tb_rv_core.sv

//--- Makefile
# Verilator flow for the single-cycle RV32I core

VERILATOR ?= verilator
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter verilog/%,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides pass or fail
sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
